// File: hw/game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// visible area and raster totals
`define SCREEN_W		64
`define SCREEN_H		48
`define LINE_TOTAL		80
`define FRAME_LINES		56
`define BORDER			2

// objects
`define BALL_SIZE		4
`define FLIP_W			16
`define FLIP_H			2
`define FLIP_Y			42
`define FLIP_STEP		2
`define BALL_START_X	30
`define BALL_START_Y	10

// RGB332 colours
`define COL_BG			8'h00
`define COL_BORDER		8'hB6
`define COL_BALL		8'hFC
`define COL_FLIP		8'h1F

`endif

// File: hw/pixelPkg.sv
package pixelPkg;

	typedef logic [7:0] coordT;
	typedef logic [7:0] rgbT;

	// current raster position
	typedef struct packed {
		coordT	x;
		coordT	y;
		logic	visible;
	} rasterT;

	// one object's contribution to a pixel
	typedef struct packed {
		logic	draw;
		rgbT	rgb;
	} layerT;

	typedef struct packed {
		coordT	x;
		coordT	y;
		logic	visible;
		rgbT	rgb;
	} pixelOutT;

endpackage

// File: hw/playPkg.sv
package playPkg;

	import pixelPkg::*;

	typedef struct packed {
		logic	left;
		logic	right;
		logic	launch;
	} keysT;

	typedef struct packed {
		coordT	x;
		coordT	y;
	} posT;

	// steps are -1 or +1 only
	typedef struct packed {
		logic signed [1:0]	dx;
		logic signed [1:0]	dy;
	} velT;

	typedef struct packed {
		logic	ballTop;
		logic	ballLeft;
		logic	ballRight;
		logic	ballBottom;
		logic	ballFlipper;
		logic	flipLeft;
		logic	flipRight;
	} hitsT;

endpackage

// File: hw/rasterTimer.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module rasterTimer import pixelPkg::*; (
	input	logic	clk,
	input	logic	arstN,
	output	rasterT	raster,
	output	logic	frameStart,
	output	logic	frameEnd
);

localparam coordT LAST_X = coordT'(`LINE_TOTAL - 1);
localparam coordT LAST_Y = coordT'(`FRAME_LINES - 1);

coordT	nextX;
coordT	nextY;

always_comb begin
	nextX = raster.x + 8'd1;
	nextY = raster.y;
	if (raster.x == LAST_X) begin
		nextX = '0;
		if (raster.y == LAST_Y)
			nextY = '0;
		else
			nextY = raster.y + 8'd1;
	end
end

always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		raster.x <= '0;
		raster.y <= '0;
		// pixel 0,0 lies inside the screen
		raster.visible <= 1'b1;
		frameEnd <= 1'b0;
		frameStart <= 1'b0;
	end else begin
		raster.x <= nextX;
		raster.y <= nextY;
		raster.visible <= (nextX < coordT'(`SCREEN_W)) && (nextY < coordT'(`SCREEN_H));
		// high while raster sits on the last count of the frame
		frameEnd <= (nextX == LAST_X) && (nextY == LAST_Y);
		// one cycle later the raster is back at 0,0
		frameStart <= frameEnd;
	end
end

endmodule

// File: hw/ballObject.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module ballObject import pixelPkg::*, playPkg::*; (
	input	logic		clk,
	input	logic		arstN,
	input	rasterT		raster,
	input	logic		frameStart,
	input	hitsT		hits,
	input	logic		launch,
	output	layerT		ballLayer,
	output	posT		ballPos,
	output	logic	[7:0]	missCount
);

localparam logic [1:0] STEP_POS = 2'b01;
localparam logic [1:0] STEP_NEG = 2'b11;

velT	vel;
velT	nextVel;
velT	moveVel;
posT	nextPos;
logic	waiting;
logic	inX;
logic	inY;

function automatic coordT extend(input logic [1:0] step);
	extend = {{6{step[1]}}, step};
endfunction

// bounce rule, flipper wins over top
always_comb begin
	nextVel = vel;
	if (hits.ballFlipper)
		nextVel.dy = STEP_NEG;
	else if (hits.ballTop)
		nextVel.dy = STEP_POS;
	if (hits.ballLeft || hits.ballRight)
		nextVel.dx = -vel.dx;
end

// a parked ball ignores the old hits on relaunch
assign moveVel = waiting ? vel : nextVel;
assign nextPos.x = ballPos.x + extend(moveVel.dx);
assign nextPos.y = ballPos.y + extend(moveVel.dy);

always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		ballPos <= '{x: coordT'(`BALL_START_X), y: coordT'(`BALL_START_Y)};
		vel <= '{dx: STEP_POS, dy: STEP_POS};
		waiting <= 1'b0;
		missCount <= '0;
	end else if (frameStart) begin
		if (waiting) begin
			if (launch) begin
				waiting <= 1'b0;
				ballPos <= nextPos;
			end
		end else if (hits.ballBottom) begin
			// missed, park at start
			ballPos <= '{x: coordT'(`BALL_START_X), y: coordT'(`BALL_START_Y)};
			vel.dy <= STEP_POS;
			waiting <= 1'b1;
			missCount <= missCount + 8'd1;
		end else begin
			vel <= nextVel;
			ballPos <= nextPos;
		end
	end
end

assign inX = (raster.x >= ballPos.x) && (raster.x < ballPos.x + coordT'(`BALL_SIZE));
assign inY = (raster.y >= ballPos.y) && (raster.y < ballPos.y + coordT'(`BALL_SIZE));

always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		ballLayer <= '0;
	end else begin
		ballLayer.draw <= inX && inY;
		ballLayer.rgb <= `COL_BALL;
	end
end

endmodule

// File: hw/flipperObject.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module flipperObject import pixelPkg::*, playPkg::*; (
	input	logic	clk,
	input	logic	arstN,
	input	rasterT	raster,
	input	logic	frameStart,
	input	hitsT	hits,
	input	logic	left,
	input	logic	right,
	output	layerT	flipLayer,
	output	posT	flipPos
);

localparam coordT MIN_X = coordT'(`BORDER);
localparam coordT MAX_X = coordT'(`SCREEN_W - `BORDER - `FLIP_W);
localparam coordT STEP = coordT'(`FLIP_STEP);

logic	inX;
logic	inY;

always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		flipPos <= '{x: coordT'((`SCREEN_W - `FLIP_W) / 2), y: coordT'(`FLIP_Y)};
	end else if (frameStart) begin
		// both keys held cancel out
		if (left && !right && !hits.flipLeft) begin
			if (flipPos.x <= MIN_X + STEP)
				flipPos.x <= MIN_X;
			else
				flipPos.x <= flipPos.x - STEP;
		end else if (right && !left && !hits.flipRight) begin
			if (flipPos.x + STEP >= MAX_X)
				flipPos.x <= MAX_X;
			else
				flipPos.x <= flipPos.x + STEP;
		end
	end
end

assign inX = (raster.x >= flipPos.x) && (raster.x < flipPos.x + coordT'(`FLIP_W));
assign inY = (raster.y >= flipPos.y) && (raster.y < flipPos.y + coordT'(`FLIP_H));

always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		flipLayer <= '0;
	end else begin
		flipLayer.draw <= inX && inY;
		flipLayer.rgb <= `COL_FLIP;
	end
end

endmodule

// File: hw/frameCompositor.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module frameCompositor import pixelPkg::*, playPkg::*; (
	input	logic		clk,
	input	logic		arstN,
	input	rasterT		raster,
	input	layerT		ballLayer,
	input	layerT		flipLayer,
	input	logic		frameEnd,
	output	pixelOutT	pixelOut,
	output	hitsT		hits
);

// raster aligned with the registered layers
rasterT	rasterD;

logic	atTop;
logic	atBottom;
logic	atLeft;
logic	atRight;
logic	onBorder;
logic	ballOn;
logic	flipOn;
rgbT	pixRgb;
hitsT	seen;
hitsT	evidence;

always_comb begin
	atTop = rasterD.visible && (rasterD.y < coordT'(`BORDER));
	atBottom = rasterD.visible && (rasterD.y >= coordT'(`SCREEN_H - `BORDER));
	atLeft = rasterD.visible && (rasterD.x < coordT'(`BORDER));
	atRight = rasterD.visible && (rasterD.x >= coordT'(`SCREEN_W - `BORDER));
	onBorder = atTop || atBottom || atLeft || atRight;
	ballOn = rasterD.visible && ballLayer.draw;
	flipOn = rasterD.visible && flipLayer.draw;
end

// ball over flipper over border over background
always_comb begin
	if (!rasterD.visible)
		pixRgb = '0;
	else if (ballLayer.draw)
		pixRgb = ballLayer.rgb;
	else if (flipLayer.draw)
		pixRgb = flipLayer.rgb;
	else if (onBorder)
		pixRgb = `COL_BORDER;
	else
		pixRgb = `COL_BG;
end

// overlaps on this pixel
always_comb begin
	seen.ballTop = ballOn && atTop;
	seen.ballLeft = ballOn && atLeft;
	seen.ballRight = ballOn && atRight;
	seen.ballBottom = ballOn && atBottom;
	seen.ballFlipper = ballOn && flipOn;
	seen.flipLeft = flipOn && atLeft;
	seen.flipRight = flipOn && atRight;
end

always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		rasterD <= '0;
		pixelOut <= '0;
		evidence <= '0;
		hits <= '0;
	end else begin
		rasterD <= raster;
		pixelOut <= '{x: rasterD.x, y: rasterD.y, visible: rasterD.visible, rgb: pixRgb};
		if (frameEnd) begin
			// publish the finished frame, start over
			hits <= evidence | seen;
			evidence <= '0;
		end else begin
			evidence <= evidence | seen;
		end
	end
end

endmodule

// File: hw/gameCore.sv
`timescale 1ns/1ps

module gameCore import pixelPkg::*, playPkg::*; (
	input	logic		clk,
	input	logic		arstN,
	input	keysT		keys,
	output	pixelOutT	pixelOut,
	output	logic		frameStart,
	output	posT		ballPos,
	output	posT		flipPos,
	output	hitsT		hits,
	output	logic	[7:0]	missCount
);

rasterT	raster;
logic	frameEnd;
layerT	ballLayer;
layerT	flipLayer;

rasterTimer rasterTimerInst (
	.clk(clk),
	.arstN(arstN),
	.raster(raster),
	.frameStart(frameStart),
	.frameEnd(frameEnd)
);

ballObject ballObjectInst (
	.clk(clk),
	.arstN(arstN),
	.raster(raster),
	.frameStart(frameStart),
	.hits(hits),
	.launch(keys.launch),
	.ballLayer(ballLayer),
	.ballPos(ballPos),
	.missCount(missCount)
);

flipperObject flipperObjectInst (
	.clk(clk),
	.arstN(arstN),
	.raster(raster),
	.frameStart(frameStart),
	.hits(hits),
	.left(keys.left),
	.right(keys.right),
	.flipLayer(flipLayer),
	.flipPos(flipPos)
);

// merges layers and judges collisions
frameCompositor frameCompositorInst (
	.clk(clk),
	.arstN(arstN),
	.raster(raster),
	.ballLayer(ballLayer),
	.flipLayer(flipLayer),
	.frameEnd(frameEnd),
	.pixelOut(pixelOut),
	.hits(hits)
);

endmodule

// File: test/gameCore_sva.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module gameCore_sva import pixelPkg::*, playPkg::*; (
	input	logic		clk,
	input	logic		arstN,
	input	logic		frameStart,
	input	logic		frameEnd,
	input	pixelOutT	pixelOut,
	input	posT		ballPos,
	input	posT		flipPos,
	input	hitsT		hits,
	input	logic	[7:0]	missCount
);

localparam coordT LAST_X = coordT'(`LINE_TOTAL - 1);
localparam coordT LAST_Y = coordT'(`FRAME_LINES - 1);
localparam coordT END_PIXEL_X = coordT'(`LINE_TOTAL - 3);
localparam coordT START_PIXEL_X = coordT'(`LINE_TOTAL - 2);

// failure count, watched by the testbench
int		assertFails = 0;
logic	heldInReset = 1'b0;
logic	[1:0]	liveCycles;
logic	settled;

always @(posedge clk) begin
	heldInReset <= !arstN;
end

// pixelOut needs two clocks after reset to carry real raster data
always_ff @(posedge clk or negedge arstN) begin
	if (!arstN) begin
		liveCycles <= '0;
	end else if (liveCycles != 2'd2) begin
		liveCycles <= liveCycles + 2'd1;
	end
end

assign settled = (liveCycles == 2'd2);

resetQuiet: assert property (@(posedge clk) (!arstN && heldInReset) |->
	!frameStart && !frameEnd && hits == '0 && missCount == '0 && !pixelOut.visible)
	else begin assertFails++; $error("outputs not quiet during reset"); end

resetPositions: assert property (@(posedge clk) (!arstN && heldInReset) |->
	ballPos.x == coordT'(`BALL_START_X) && ballPos.y == coordT'(`BALL_START_Y) &&
	flipPos.x == coordT'((`SCREEN_W - `FLIP_W) / 2) && flipPos.y == coordT'(`FLIP_Y))
	else begin assertFails++; $error("object positions wrong during reset"); end

// frameEnd sits on the last count, two pixels ahead of pixelOut
endOnLastCount: assert property (@(posedge clk) disable iff (!arstN)
	frameEnd == (pixelOut.x == END_PIXEL_X && pixelOut.y == LAST_Y))
	else begin assertFails++; $error("frameEnd not on the last count"); end

// frameStart one count later, with the raster back at 0,0
startOnFirstCount: assert property (@(posedge clk) disable iff (!arstN)
	frameStart == (pixelOut.x == START_PIXEL_X && pixelOut.y == LAST_Y))
	else begin assertFails++; $error("frameStart not one cycle after frameEnd"); end

pixelStep: assert property (@(posedge clk) disable iff (!arstN)
	(settled && pixelOut.x != LAST_X) |=>
	pixelOut.x == $past(pixelOut.x) + 8'd1 && pixelOut.y == $past(pixelOut.y))
	else begin assertFails++; $error("pixelOut x did not step by one"); end

lineWrap: assert property (@(posedge clk) disable iff (!arstN)
	(settled && pixelOut.x == LAST_X) |=> pixelOut.x == coordT'(0) &&
	pixelOut.y == (($past(pixelOut.y) == LAST_Y) ? coordT'(0) : $past(pixelOut.y) + 8'd1))
	else begin assertFails++; $error("pixelOut line wrap out of order"); end

visibleArea: assert property (@(posedge clk) disable iff (!arstN)
	settled |-> pixelOut.visible ==
	(pixelOut.x < coordT'(`SCREEN_W) && pixelOut.y < coordT'(`SCREEN_H)))
	else begin assertFails++; $error("visible flag wrong for coordinates"); end

endmodule

// File: test/gameCore_tb.sv
`timescale 1ns/1ps
`include "game_defines.svh"

module gameCore_tb import pixelPkg::*, playPkg::*; ();

localparam int CLK_PERIOD = 8;
localparam int FRAME_CYCLES = `LINE_TOTAL * `FRAME_LINES;
localparam int RUN_FRAMES = 40;
localparam int MARGIN_FRAMES = 4;
localparam int WATCHDOG_NS = (RUN_FRAMES + MARGIN_FRAMES) * FRAME_CYCLES * CLK_PERIOD;

logic		clk;
logic		arstN;
keysT		keys;
pixelOutT	pixelOut;
logic		frameStart;
posT		ballPos;
posT		flipPos;
hitsT		hits;
logic	[7:0]	missCount;

// reference model state
int		ballX;
int		ballY;
int		velX;
int		velY;
int		flipX;
int		misses;
logic	parked;
hitsT	evidence;
int		missWait;

gameCore dut0 (
	.clk(clk),
	.arstN(arstN),
	.keys(keys),
	.pixelOut(pixelOut),
	.frameStart(frameStart),
	.ballPos(ballPos),
	.flipPos(flipPos),
	.hits(hits),
	.missCount(missCount)
);

bind gameCore gameCore_sva svaInst (
	.clk(clk),
	.arstN(arstN),
	.frameStart(frameStart),
	.frameEnd(frameEnd),
	.pixelOut(pixelOut),
	.ballPos(ballPos),
	.flipPos(flipPos),
	.hits(hits),
	.missCount(missCount)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

task automatic checkEqual(input string testName, input int expected, input int actual);
	assert (expected == actual) else begin
		$display("** Error %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
		$display("Simulation failed");
		$fatal(1, "value mismatch");
	end
endtask

// returns 1 ns after the edge that applies a frameStart
task automatic waitFrames(input int count);
	repeat (count) begin
		do
			@(negedge clk);
		while (!frameStart);
		@(posedge clk);
		#1;
	end
endtask

function automatic bit onBall(input int x, input int y);
	return x >= ballX && x < ballX + `BALL_SIZE && y >= ballY && y < ballY + `BALL_SIZE;
endfunction

function automatic bit onFlipper(input int x, input int y);
	return x >= flipX && x < flipX + `FLIP_W && y >= `FLIP_Y && y < `FLIP_Y + `FLIP_H;
endfunction

function automatic int expectColour(input int x, input int y);
	if (onBall(x, y))
		return `COL_BALL;
	if (onFlipper(x, y))
		return `COL_FLIP;
	if (x < `BORDER || x >= `SCREEN_W - `BORDER || y < `BORDER || y >= `SCREEN_H - `BORDER)
		return `COL_BORDER;
	return `COL_BG;
endfunction

task automatic collectEvidence(input int x, input int y);
	bit ballOn;
	bit flipOn;
	ballOn = onBall(x, y);
	flipOn = onFlipper(x, y);
	evidence.ballTop |= ballOn && (y < `BORDER);
	evidence.ballBottom |= ballOn && (y >= `SCREEN_H - `BORDER);
	evidence.ballLeft |= ballOn && (x < `BORDER);
	evidence.ballRight |= ballOn && (x >= `SCREEN_W - `BORDER);
	evidence.ballFlipper |= ballOn && flipOn;
	evidence.flipLeft |= flipOn && (x < `BORDER);
	evidence.flipRight |= flipOn && (x >= `SCREEN_W - `BORDER);
endtask

// per-frame update from the previous frame's hits
task automatic advanceModel;
	if (parked) begin
		if (keys.launch) begin
			parked = 1'b0;
			ballX += velX;
			ballY += velY;
		end
	end else if (evidence.ballBottom) begin
		ballX = `BALL_START_X;
		ballY = `BALL_START_Y;
		velY = 1;
		parked = 1'b1;
		misses++;
	end else begin
		if (evidence.ballFlipper)
			velY = -1;
		else if (evidence.ballTop)
			velY = 1;
		if (evidence.ballLeft || evidence.ballRight)
			velX = -velX;
		ballX += velX;
		ballY += velY;
	end
	if (keys.left && !keys.right && !evidence.flipLeft)
		flipX = (flipX - `FLIP_STEP < `BORDER) ? `BORDER : flipX - `FLIP_STEP;
	else if (keys.right && !keys.left && !evidence.flipRight)
		flipX = (flipX + `FLIP_STEP > `SCREEN_W - `BORDER - `FLIP_W) ?
			`SCREEN_W - `BORDER - `FLIP_W : flipX + `FLIP_STEP;
endtask

always @(negedge clk) begin
	if (!arstN) begin
		ballX = `BALL_START_X;
		ballY = `BALL_START_Y;
		velX = 1;
		velY = 1;
		flipX = (`SCREEN_W - `FLIP_W) / 2;
		misses = 0;
		parked = 1'b0;
		evidence = '0;
	end else begin
		if (pixelOut.visible) begin
			checkEqual("pixel colour", expectColour(int'(pixelOut.x), int'(pixelOut.y)),
				int'(pixelOut.rgb));
			collectEvidence(int'(pixelOut.x), int'(pixelOut.y));
		end
		checkEqual("ball x", ballX, int'(ballPos.x));
		checkEqual("ball y", ballY, int'(ballPos.y));
		checkEqual("flipper x", flipX, int'(flipPos.x));
		checkEqual("flipper y", `FLIP_Y, int'(flipPos.y));
		checkEqual("miss count", misses, int'(missCount));
		if (frameStart) begin
			checkEqual("frame hits", int'(evidence), int'(hits));
			advanceModel();
			evidence = '0;
		end
	end
end

always @(negedge clk) begin
	if (dut0.svaInst.assertFails != 0) begin
		$display("Simulation failed");
		$fatal(1, "a concurrent assertion on the DUT failed");
	end
end

initial begin
	#(WATCHDOG_NS);
	$display("Simulation failed");
	$fatal(1, "watchdog expired before the test sequence finished");
end

initial begin
	void'($urandom(92));
	arstN = 1'b0;
	keys = '0;
	repeat (10) @(posedge clk);
	#1;
	arstN = 1'b1;
	// random flipper holds
	repeat (6) begin
		keys.left = 1'($urandom % 2);
		keys.right = 1'($urandom % 2);
		waitFrames(1);
	end
	keys.left = 1'b1;
	keys.right = 1'b0;
	waitFrames(18);
	checkEqual("flipper parked left", `BORDER, int'(flipPos.x));
	// ball runs past the flipper to the bottom
	missWait = 0;
	while (missCount == 8'd0 && missWait < 16) begin
		waitFrames(1);
		missWait++;
	end
	checkEqual("miss counted", 1, int'(missCount));
	checkEqual("ball back at start x", `BALL_START_X, int'(ballPos.x));
	checkEqual("ball back at start y", `BALL_START_Y, int'(ballPos.y));
	waitFrames(3);
	checkEqual("ball waits for launch", `BALL_START_Y, int'(ballPos.y));
	keys.launch = 1'b1;
	waitFrames(1);
	checkEqual("ball relaunched", `BALL_START_Y + 1, int'(ballPos.y));
	waitFrames(2);
	if (dut0.svaInst.assertFails == 0) begin
		$display("Simulation completed successfully");
		$finish;
	end else begin
		$display("Simulation failed");
		$fatal(1, "concurrent assertions failed during the run");
	end
end

endmodule

// File: sim.f
+incdir+hw
hw/pixelPkg.sv
hw/playPkg.sv
hw/rasterTimer.sv
hw/ballObject.sv
hw/flipperObject.sv
hw/frameCompositor.sv
hw/gameCore.sv
test/gameCore_sva.sv
test/gameCore_tb.sv

// File: Makefile
SIM      = verilator
TOP      = gameCore_tb
FILELIST = sim.f
OBJDIR   = obj_dir
FLAGS    = --binary --timing --assert --top-module $(TOP) -Mdir $(OBJDIR)
RUNARGS  = +verilator+error+limit+100

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# exit status follows $fatal or $finish
run: compile
	./$(OBJDIR)/V$(TOP) $(RUNARGS)

clean:
	rm -rf $(OBJDIR)
